/* image_pkg.sv */
package image_pkg;

    localparam int unsigned channel_w = 8;  // bits per colour channel.
    localparam int unsigned gray_w    = 8;  // bits per gray level.

    typedef logic [channel_w-1:0] channel_t;

    // one rgb pixel as it arrives from the source, red in the top byte.
    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_pixel_t;

    typedef logic [gray_w-1:0] gray_t;  // truncated channel mean.

    // width of the channel sum, wide enough for three full channels.
    localparam int unsigned channel_sum_w = channel_w + 2;

    typedef logic [channel_sum_w-1:0] channel_sum_t;

endpackage

/* mem_pkg.sv */
package mem_pkg;

    localparam int unsigned mem_addr_w = 32;   // word address width.
    localparam int unsigned mem_data_w = 128;  // memory word width.

    typedef logic [mem_addr_w-1:0] mem_addr_t;
    typedef logic [mem_data_w-1:0] mem_word_t;

    // command from the client to the memory port, one cycle per command.
    typedef struct packed {
        mem_addr_t address;
        mem_word_t write_data;
        logic      rd_en;
        logic      wr_en;
    } mem_cmd_t;

    // response from the memory port back to the client.
    typedef struct packed {
        mem_word_t read_data;       // valid with read_complete, then held.
        logic      write_complete;  // one-cycle pulse.
        logic      read_complete;   // one-cycle pulse.
    } mem_rsp_t;

    localparam mem_cmd_t mem_cmd_idle = '{
        address:    '0,
        write_data: '0,
        rd_en:      1'b0,
        wr_en:      1'b0
    };

endpackage

/* pixel_fifo.sv */
`timescale 1ns/100ps

module pixel_fifo #(
    parameter type         payload_t  = logic [7:0],
    parameter int unsigned fifo_depth = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     push,
    input  payload_t din,
    output logic     full,
    input  logic     pop,
    output payload_t dout,
    output logic     empty
);

    localparam int unsigned ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int unsigned cnt_w = $clog2(fifo_depth + 1);

    payload_t storage [fifo_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;  // a push into a full fifo is dropped.
    assign do_pop  = pop && !empty;

    assign full  = (count == cnt_w'(fifo_depth));
    assign empty = (count == '0);
    assign dout  = storage[rd_ptr];  // oldest entry falls through.

    always_ff @(posedge clock) begin
        if (do_push) begin
            storage[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == ptr_w'(fifo_depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == ptr_w'(fifo_depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // simultaneous push and pop leaves the count alone.
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* grayscale.sv */
`timescale 1ns/100ps

module grayscale
    import image_pkg::*;
    import mem_pkg::*;
#(
    parameter mem_addr_t   frame_base  = 32'h0100_0000,
    parameter int unsigned frame_words = 16
) (
    input  logic       clock,
    input  logic       reset,
    output logic       in_rd_en,
    input  logic       in_empty,
    input  rgb_pixel_t in_dout,
    output mem_cmd_t   mem_cmd,
    input  mem_rsp_t   mem_rsp,
    output logic       out_wr_en,
    input  logic       out_full,
    output gray_t      out_din
);

    localparam int unsigned offset_w = (frame_words > 1) ? $clog2(frame_words) : 1;

    typedef enum logic [2:0] {
        st_idle,
        st_write,
        st_write_wait,
        st_read,
        st_read_wait,
        st_capture,
        st_output
    } state_t;

    state_t state;
    state_t next_state;

    logic [offset_w-1:0] frame_offset;  // word offset inside the frame region.
    channel_sum_t        channel_sum;
    gray_t               gray_mean;
    gray_t               gray_q;        // value sent to memory.
    gray_t               readback_q;    // value returned by memory.
    mem_addr_t           pixel_addr;

    // sum of three channels cannot overflow channel_sum_t.
    assign channel_sum = channel_sum_t'(in_dout.red) + channel_sum_t'(in_dout.green)
                       + channel_sum_t'(in_dout.blue);
    assign gray_mean   = gray_t'(channel_sum / channel_sum_t'(3));
    assign pixel_addr  = frame_base + mem_addr_t'(frame_offset);
    assign out_din     = readback_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state        <= st_idle;
            frame_offset <= '0;
        end else begin
            state <= next_state;
            if (out_wr_en) begin
                if (frame_offset == offset_w'(frame_words - 1)) begin
                    frame_offset <= '0;  // wrap to the start of the frame.
                end else begin
                    frame_offset <= frame_offset + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            gray_q <= gray_mean;
        end
        if (state == st_capture) begin
            readback_q <= mem_rsp.read_data[gray_w-1:0];  // gray sits in the low byte.
        end
    end

    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;
        mem_cmd    = mem_cmd_idle;

        case (state)
            st_idle: begin
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    next_state = st_write;
                end
            end
            st_write: begin
                mem_cmd.address    = pixel_addr;
                mem_cmd.write_data = mem_word_t'(gray_q);  // upper bytes zero.
                mem_cmd.wr_en      = 1'b1;
                next_state         = st_write_wait;
            end
            st_write_wait: begin
                if (mem_rsp.write_complete) begin
                    next_state = st_read;
                end
            end
            st_read: begin
                mem_cmd.address = pixel_addr;  // same word that was just written.
                mem_cmd.rd_en   = 1'b1;
                next_state      = st_read_wait;
            end
            st_read_wait: begin
                if (mem_rsp.read_complete) begin
                    next_state = st_capture;
                end
            end
            st_capture: begin
                next_state = st_output;
            end
            st_output: begin
                // hold here while the output fifo is full.
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

/* frame_memory.sv */
`timescale 1ns/100ps

module frame_memory
    import mem_pkg::*;
#(
    parameter int unsigned frame_words = 16,
    parameter int unsigned mem_latency = 3
) (
    input  logic     clock,
    input  logic     reset,
    input  mem_cmd_t mem_cmd,
    output mem_rsp_t mem_rsp
);

    localparam int unsigned idx_w = (frame_words > 1) ? $clog2(frame_words) : 1;
    localparam int unsigned cnt_w = $clog2(mem_latency + 1);

    mem_word_t storage [frame_words];

    logic [idx_w-1:0] index;
    logic [cnt_w-1:0] countdown;  // cycles left until completion.
    logic             op_read;    // kind of the pending command.
    mem_word_t        read_word;
    logic             last_cycle;

    // the frame region maps onto the array by word address modulo its size.
    assign index = idx_w'(mem_cmd.address % frame_words);

    // writes land at command time, reads sample at command time too.
    always_ff @(posedge clock) begin
        if (mem_cmd.wr_en) begin
            storage[index] <= mem_cmd.write_data;
        end
        if (mem_cmd.rd_en) begin
            read_word <= storage[index];  // held until the next read.
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            countdown <= '0;
            op_read   <= 1'b0;
        end else begin
            if (mem_cmd.wr_en || mem_cmd.rd_en) begin
                countdown <= cnt_w'(mem_latency);
                op_read   <= mem_cmd.rd_en;
            end else if (countdown != '0) begin
                countdown <= countdown - 1'b1;
            end
        end
    end

    // countdown reaches one exactly mem_latency cycles after the command.
    assign last_cycle = (countdown == cnt_w'(1));

    always_comb begin
        mem_rsp.read_data      = read_word;
        mem_rsp.write_complete = last_cycle && !op_read;
        mem_rsp.read_complete  = last_cycle && op_read;
    end

endmodule

/* grayscale_top.sv */
`timescale 1ns/100ps

module grayscale_top
    import image_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned fifo_depth  = 8,
    parameter mem_addr_t   frame_base  = 32'h0100_0000,
    parameter int unsigned frame_words = 16,
    parameter int unsigned mem_latency = 3
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       pixel_push,
    input  rgb_pixel_t pixel_in,
    output logic       in_full,
    input  logic       gray_pop,
    output gray_t      gray_out,
    output logic       gray_empty
);

    logic       in_empty;
    logic       in_rd_en;
    rgb_pixel_t in_dout;
    logic       out_wr_en;
    logic       out_full;
    gray_t      out_din;
    mem_cmd_t   mem_cmd;
    mem_rsp_t   mem_rsp;

    pixel_fifo #(
        .payload_t  (rgb_pixel_t),
        .fifo_depth (fifo_depth)
    ) i_in_fifo (
        .clock (clock),
        .reset (reset),
        .push  (pixel_push),
        .din   (pixel_in),
        .full  (in_full),
        .pop   (in_rd_en),
        .dout  (in_dout),
        .empty (in_empty)
    );

    grayscale #(
        .frame_base  (frame_base),
        .frame_words (frame_words)
    ) i_grayscale (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (in_rd_en),
        .in_empty  (in_empty),
        .in_dout   (in_dout),
        .mem_cmd   (mem_cmd),
        .mem_rsp   (mem_rsp),
        .out_wr_en (out_wr_en),
        .out_full  (out_full),
        .out_din   (out_din)
    );

    frame_memory #(
        .frame_words (frame_words),
        .mem_latency (mem_latency)
    ) i_frame_memory (
        .clock   (clock),
        .reset   (reset),
        .mem_cmd (mem_cmd),
        .mem_rsp (mem_rsp)
    );

    pixel_fifo #(
        .payload_t  (gray_t),
        .fifo_depth (fifo_depth)
    ) i_out_fifo (
        .clock (clock),
        .reset (reset),
        .push  (out_wr_en),
        .din   (out_din),
        .full  (out_full),
        .pop   (gray_pop),
        .dout  (gray_out),
        .empty (gray_empty)
    );

endmodule

/* grayscale_properties.sv */
`timescale 1ns/100ps

module grayscale_properties
    import mem_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input logic     in_rd_en,
    input logic     in_empty,
    input mem_cmd_t mem_cmd,
    input mem_rsp_t mem_rsp,
    input logic     out_wr_en,
    input logic     out_full
);

    logic cmd_seen;
    logic cmd_pending;  // a command waits for its completion.

    assign cmd_seen = mem_cmd.wr_en || mem_cmd.rd_en;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmd_pending <= 1'b0;
        end else if (cmd_seen) begin
            cmd_pending <= 1'b1;
        end else if (mem_rsp.write_complete || mem_rsp.read_complete) begin
            cmd_pending <= 1'b0;
        end
    end

    a_single_op: assert property (@(posedge clock) disable iff (reset)
        !(mem_cmd.wr_en && mem_cmd.rd_en))
        else $error("write and read command in the same cycle");

    a_pop_not_empty: assert property (@(posedge clock) disable iff (reset)
        in_rd_en |-> !in_empty)
        else $error("pop from an empty input fifo");

    a_push_not_full: assert property (@(posedge clock) disable iff (reset)
        out_wr_en |-> !out_full)
        else $error("push into a full output fifo");

    a_one_in_flight: assert property (@(posedge clock) disable iff (reset)
        cmd_seen |-> !cmd_pending)
        else $error("memory command issued before the previous completion");

endmodule

bind grayscale grayscale_properties i_grayscale_properties (.*);

/* tb_grayscale.sv */
`timescale 1ns/100ps

module tb_grayscale
    import image_pkg::*;
();

    localparam int unsigned fifo_depth     = 8;
    localparam int unsigned chain_capacity = 2 * fifo_depth + 1;  // both fifos plus one held.
    localparam int unsigned wait_limit     = 200;                 // cycles per wait.
    localparam logic [31:0] lfsr_seed      = 32'h15a3_9670;
    localparam logic [31:0] lfsr_taps      = 32'h8020_0003;
    localparam int unsigned table_len      = 10;

    typedef struct packed {
        rgb_pixel_t pixel;
        gray_t      gray;
    } table_entry_t;

    // expected gray is floor((r + g + b) / 3).
    localparam table_entry_t stim_table [table_len] = '{
        '{24'h00_00_00, 8'd0},    // all zero.
        '{24'hff_ff_ff, 8'd255},  // all full scale.
        '{24'hff_00_00, 8'd85},
        '{24'h00_ff_00, 8'd85},
        '{24'h00_00_ff, 8'd85},
        '{24'h01_00_00, 8'd0},    // remainder 1.
        '{24'h01_01_00, 8'd0},    // remainder 2.
        '{24'h64_64_65, 8'd100},  // 301, remainder 1.
        '{24'h80_80_82, 8'd128},  // 386, remainder 2.
        '{24'h12_34_56, 8'd52}
    };

    logic       clock;
    logic       reset;
    logic       pixel_push;
    rgb_pixel_t pixel_in;
    logic       in_full;
    logic       gray_pop;
    gray_t      gray_out;
    logic       gray_empty;

    logic [31:0] lfsr_state;
    gray_t       expect_q [$];
    int unsigned check_count;
    int unsigned error_count;
    int unsigned test_count;
    int unsigned errors_at_start;

    grayscale_top #(
        .fifo_depth (fifo_depth)
    ) i_grayscale_top (
        .clock      (clock),
        .reset      (reset),
        .pixel_push (pixel_push),
        .pixel_in   (pixel_in),
        .in_full    (in_full),
        .gray_pop   (gray_pop),
        .gray_out   (gray_out),
        .gray_empty (gray_empty)
    );

    always #4 clock = ~clock;  // 8 ns period.

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [31:0] random_bits(input int unsigned n);
        logic [31:0] value;
        int unsigned i;
        value = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic rgb_pixel_t random_pixel();
        logic [31:0] bits;
        bits = random_bits(24);
        return bits[23:0];
    endfunction

    function automatic gray_t expected_gray(input rgb_pixel_t p);
        int unsigned sum;
        sum = int'(p.red) + int'(p.green) + int'(p.blue);
        return gray_t'(sum / 3);
    endfunction

    task automatic check_gray(input string what, input gray_t actual, input gray_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s expected 'h%02h got 'h%02h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, what, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s within %0d cycles", $time, what, wait_limit);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic start_test();
        errors_at_start = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name,
                     error_count - errors_at_start);
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset      <= 1'b1;
        pixel_push <= 1'b0;
        gray_pop   <= 1'b0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic check_idle(input int unsigned cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_flag("gray_empty when idle", gray_empty, 1'b1);
            check_flag("in_full when idle", in_full, 1'b0);
        end
    endtask

    // the pixel is taken on the edge after in_full is seen low.
    task automatic push_pixel(input rgb_pixel_t p);
        int unsigned waited;
        waited = 0;
        @(posedge clock);
        pixel_push <= 1'b1;
        pixel_in   <= p;
        @(negedge clock);
        while (in_full) begin
            waited++;
            if (waited > wait_limit) begin
                report_timeout("input fifo did not leave the full state");
            end
            @(negedge clock);
        end
        @(posedge clock);
        pixel_push <= 1'b0;
    endtask

    task automatic pop_and_check(input int unsigned n);
        int unsigned i;
        int unsigned waited;
        gray_t       expected;
        for (i = 0; i < n; i++) begin
            waited = 0;
            @(negedge clock);
            while (gray_empty) begin
                waited++;
                if (waited > wait_limit) begin
                    report_timeout("no gray value reached the output fifo");
                end
                @(negedge clock);
            end
            expected = expect_q.pop_front();
            check_gray("gray_out", gray_out, expected);
            @(posedge clock);
            gray_pop <= 1'b1;
            @(posedge clock);
            gray_pop <= 1'b0;
        end
    endtask

    task automatic run_table();
        int unsigned i;
        fork
            begin
                for (i = 0; i < table_len; i++) begin
                    expect_q.push_back(stim_table[i].gray);
                    push_pixel(stim_table[i].pixel);
                end
            end
            pop_and_check(table_len);
        join
    endtask

    task automatic run_random(input int unsigned n);
        int unsigned i;
        int unsigned gap;
        rgb_pixel_t  p;
        fork
            begin
                for (i = 0; i < n; i++) begin
                    gap = random_bits(2);
                    repeat (gap) @(posedge clock);
                    p = random_pixel();
                    expect_q.push_back(expected_gray(p));
                    push_pixel(p);
                end
            end
            pop_and_check(n);
        join
    endtask

    // push every cycle with the sink stalled, counting taken and refused pushes.
    task automatic run_back_pressure();
        int unsigned accepted;
        int unsigned refused;
        int unsigned cycle;
        rgb_pixel_t  p;
        accepted = 0;
        refused  = 0;
        p        = random_pixel();
        @(posedge clock);
        pixel_push <= 1'b1;
        pixel_in   <= p;
        for (cycle = 0; cycle < 300; cycle++) begin
            @(negedge clock);
            if (!in_full) begin
                accepted++;
                expect_q.push_back(expected_gray(p));
                @(posedge clock);
                p = random_pixel();
            end else begin
                refused++;
                @(posedge clock);
                p = random_pixel();  // a refused pixel must never appear.
            end
            pixel_in <= p;
        end
        pixel_push <= 1'b0;
        @(negedge clock);
        check_flag("in_full with the chain stalled", in_full, 1'b1);
        check_flag("pushes were refused while full", refused > 0, 1'b1);
        check_flag("chain holds its full capacity", accepted == chain_capacity, 1'b1);
        pop_and_check(accepted);
        check_idle(20);
    endtask

    // the whole chain is filled so that reset meets both fifos occupied.
    task automatic run_reset_mid_stream();
        int unsigned i;
        int unsigned waited;
        for (i = 0; i < chain_capacity; i++) begin
            push_pixel(random_pixel());
        end
        waited = 0;
        @(negedge clock);
        while (!in_full) begin
            waited++;
            if (waited > wait_limit) begin
                report_timeout("input fifo did not fill before the mid-stream reset");
            end
            @(negedge clock);
        end
        apply_reset();
        check_idle(8);
        run_table();
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        pixel_push  = 1'b0;
        pixel_in    = '0;
        gray_pop    = 1'b0;
        lfsr_state  = lfsr_seed;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        apply_reset();

        start_test();
        check_idle(10);
        finish_test("reset state");

        start_test();
        run_table();
        finish_test("table conversion");

        start_test();
        run_random(40);
        finish_test("random stream");

        start_test();
        run_back_pressure();
        finish_test("back-pressure");

        start_test();
        run_reset_mid_stream();
        finish_test("reset in mid-stream");

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
image_pkg.sv
mem_pkg.sv
pixel_fifo.sv
grayscale.sv
frame_memory.sv
grayscale_top.sv
grayscale_properties.sv
tb_grayscale.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_grayscale -f tb.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_grayscale > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation finished cleanly"
